// ==== design/booth_cfg_pkg.sv ====
package booth_cfg_pkg;

    // operand width, both inputs are signed two's complement
    localparam int DATA_W = 8;

    // full signed product, no truncation
    localparam int PROD_W = 2 * DATA_W;

    // radix-2 booth retires one multiplier bit per step
    localparam int STEPS = DATA_W;

    // counter only has to reach STEPS-1
    localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;

    // count value seen in the final step cycle
    localparam int LAST_CNT = STEPS - 1;

endpackage

// ==== design/booth_ctrl_pkg.sv ====
package booth_ctrl_pkg;

    // fsm states
    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_MULT = 1'b1
    } booth_state_t;

    // register load select
    localparam int LOAD_SEL_W = 2;

    localparam logic [LOAD_SEL_W-1:0] SEL_HOLD  = 2'b00; // keep A/Q/Q-1/M
    localparam logic [LOAD_SEL_W-1:0] SEL_LOAD  = 2'b01; // take new operands
    localparam logic [LOAD_SEL_W-1:0] SEL_SHIFT = 2'b10; // take shifted step result

    // addend select for the add/subtract
    localparam logic ADDEND_ZERO = 1'b0; // A passes unchanged
    localparam logic ADDEND_M    = 1'b1; // A plus or minus M

    // alu_sub values
    localparam logic ALU_ADD = 1'b0;
    localparam logic ALU_SUB = 1'b1;

endpackage

// ==== design/booth_controller.sv ====
`timescale 1ns/1ps

module booth_controller (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic                                  q0,
    input  logic                                  q_minus1,
    input  logic                                  last_step,
    output logic [booth_ctrl_pkg::LOAD_SEL_W-1:0] load_sel,
    output logic                                  addend_sel,
    output logic                                  alu_sub,
    output logic                                  count_en,
    output logic                                  product_en,
    output logic                                  clear,
    output logic                                  ready,
    output logic                                  busy
);
    import booth_ctrl_pkg::*;

    booth_state_t state;
    booth_state_t state_next;

    logic addend_dec; // addend choice for current booth pair
    logic sub_dec;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // booth pair {Q0, Q-1}
    always_comb begin
        addend_dec = ADDEND_ZERO;
        sub_dec    = ALU_ADD;
        case ({q0, q_minus1})
            2'b10: begin
                addend_dec = ADDEND_M; // start of a run of ones
                sub_dec    = ALU_SUB;
            end
            2'b01: begin
                addend_dec = ADDEND_M; // end of a run of ones
                sub_dec    = ALU_ADD;
            end
            default: begin
                addend_dec = ADDEND_ZERO; // inside a run, shift only
                sub_dec    = ALU_ADD;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        load_sel   = SEL_HOLD;
        addend_sel = ADDEND_ZERO;
        alu_sub    = ALU_ADD;
        count_en   = 1'b0;
        product_en = 1'b0;
        clear      = 1'b0;
        ready      = 1'b0;
        busy       = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    load_sel   = SEL_LOAD;
                    state_next = ST_MULT;
                end else begin
                    clear = 1'b1; // counter parked at zero
                end
            end
            ST_MULT: begin
                busy       = 1'b1;
                load_sel   = SEL_SHIFT;
                addend_sel = addend_dec;
                alu_sub    = sub_dec;
                count_en   = 1'b1;
                if (last_step) begin
                    product_en = 1'b1; // shifted word is the product
                    ready      = 1'b1;
                    clear      = 1'b1;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

endmodule

// ==== design/booth_step_counter.sv ====
`timescale 1ns/1ps

module booth_step_counter (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic count_en,
    output logic last_step
);
    import booth_cfg_pkg::*;

    logic [CNT_W-1:0] count;

    // clear wins over count_en in the final step
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_en) begin
            count <= count + 1'b1;
        end
    end

    assign last_step = (count == CNT_W'(LAST_CNT));

endmodule

// ==== design/booth_datapath.sv ====
`timescale 1ns/1ps

module booth_datapath (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [booth_ctrl_pkg::LOAD_SEL_W-1:0] load_sel,
    input  logic                                  addend_sel,
    input  logic                                  alu_sub,
    input  logic                                  product_en,
    input  logic [booth_cfg_pkg::DATA_W-1:0]      multiplicand,
    input  logic [booth_cfg_pkg::DATA_W-1:0]      multiplier,
    output logic                                  q0,
    output logic                                  q_minus1,
    output logic [booth_cfg_pkg::PROD_W-1:0]      product
);
    import booth_cfg_pkg::*;
    import booth_ctrl_pkg::*;

    // step registers
    logic [DATA_W-1:0] a_reg;
    logic [DATA_W-1:0] q_reg;
    logic [DATA_W-1:0] m_reg;
    logic              q_m1_reg;

    // one guard bit so A - M cannot wrap
    logic [DATA_W:0] a_ext;
    logic [DATA_W:0] addend_ext;
    logic [DATA_W:0] sum_ext;

    // after the arithmetic right shift
    logic [DATA_W-1:0] a_shift;
    logic [DATA_W-1:0] q_shift;
    logic              q_m1_shift;
    logic [PROD_W-1:0] shifted_word;

    assign a_ext = {a_reg[DATA_W-1], a_reg};

    always_comb begin
        if (addend_sel == ADDEND_M) begin
            addend_ext = {m_reg[DATA_W-1], m_reg};
        end else begin
            addend_ext = '0;
        end
    end

    always_comb begin
        if (alu_sub == ALU_SUB) begin
            sum_ext = a_ext - addend_ext;
        end else begin
            sum_ext = a_ext + addend_ext;
        end
    end

    // shift {sum, Q, Q-1} right by one; guard bit becomes the new A sign
    always_comb begin
        a_shift    = sum_ext[DATA_W:1];
        q_shift    = {sum_ext[0], q_reg[DATA_W-1:1]};
        q_m1_shift = q_reg[0];
    end

    assign shifted_word = {a_shift, q_shift};

    always_ff @(posedge clk) begin
        case (load_sel)
            SEL_LOAD: begin
                a_reg    <= '0;
                q_reg    <= multiplier;
                q_m1_reg <= 1'b0;
                m_reg    <= multiplicand; // M stays fixed for the whole product
            end
            SEL_SHIFT: begin
                a_reg    <= a_shift;
                q_reg    <= q_shift;
                q_m1_reg <= q_m1_shift;
            end
            default: begin
                a_reg    <= a_reg;
                q_reg    <= q_reg;
                q_m1_reg <= q_m1_reg;
            end
        endcase
    end

    // result held until the next product_en
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            product <= '0;
        end else if (product_en) begin
            product <= shifted_word;
        end
    end

    assign q0       = q_reg[0];
    assign q_minus1 = q_m1_reg;

endmodule

// ==== design/booth_multiplier.sv ====
`timescale 1ns/1ps

module booth_multiplier (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic [booth_cfg_pkg::DATA_W-1:0] multiplicand,
    input  logic [booth_cfg_pkg::DATA_W-1:0] multiplier,
    output logic [booth_cfg_pkg::PROD_W-1:0] product,
    output logic                             done,
    output logic                             busy
);
    import booth_ctrl_pkg::*;

    logic [LOAD_SEL_W-1:0] load_sel;
    logic                  addend_sel;
    logic                  alu_sub;
    logic                  product_en;
    logic                  count_en;
    logic                  clear;
    logic                  last_step;
    logic                  q0;
    logic                  q_minus1;
    logic                  ready;

    booth_controller u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .q0         (q0),
        .q_minus1   (q_minus1),
        .last_step  (last_step),
        .load_sel   (load_sel),
        .addend_sel (addend_sel),
        .alu_sub    (alu_sub),
        .count_en   (count_en),
        .product_en (product_en),
        .clear      (clear),
        .ready      (ready),
        .busy       (busy)
    );

    booth_step_counter u_cnt (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .count_en  (count_en),
        .last_step (last_step)
    );

    booth_datapath u_dp (
        .clk          (clk),
        .rst          (rst),
        .load_sel     (load_sel),
        .addend_sel   (addend_sel),
        .alu_sub      (alu_sub),
        .product_en   (product_en),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .q0           (q0),
        .q_minus1     (q_minus1),
        .product      (product)
    );

    // same edge as the product register write
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done <= 1'b0;
        end else begin
            done <= ready;
        end
    end

endmodule

// ==== verif/booth_tb.sv ====
`timescale 1ns/1ps

module booth_tb;
    import booth_cfg_pkg::*;
    import booth_ctrl_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int MAX_TESTS    = 40;
    localparam int CYCLE_LIMIT  = MAX_TESTS * (STEPS + 6) + RESET_CYCLES;
    localparam int WAIT_LIMIT   = 2 * STEPS + 4; // per product, well past done
    localparam logic [31:0] SEED = 32'h5c85_6f25;

    logic              clk;
    logic              rst;
    logic              start;
    logic [DATA_W-1:0] multiplicand;
    logic [DATA_W-1:0] multiplier;
    logic [PROD_W-1:0] product;
    logic              done;
    logic              busy;

    logic [PROD_W-1:0] expected_product;

    int cycle_count;
    int test_err;
    int tests_run;
    int tests_failed;
    int assert_err;

    booth_multiplier dut (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .done         (done),
        .busy         (busy)
    );

    always #2 clk = ~clk;

    // done is a single-cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (!rst)
        done |-> !$past(done))
        else begin
            assert_err++;
            $display("done stayed high for two cycles in a row at t=%0t", $time);
        end

    reset_quiet: assert property (@(posedge clk) !rst |-> (!busy && !done))
        else begin
            assert_err++;
            $display("busy or done was high during reset at t=%0t", $time);
        end

    done_product: assert property (@(posedge clk) disable iff (!rst)
        done |-> (product == expected_product))
        else begin
            assert_err++;
            $display("Fail t=%0t product expected %h actual %h",
                     $time, expected_product, $sampled(product));
        end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    // reference, both operands sign extended to the full product width
    function automatic logic [PROD_W-1:0] signed_product(
        input logic signed [DATA_W-1:0] a,
        input logic signed [DATA_W-1:0] b
    );
        logic signed [PROD_W-1:0] wide_a;
        logic signed [PROD_W-1:0] wide_b;
        wide_a = a;
        wide_b = b;
        return wide_a * wide_b;
    endfunction

    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            test_err++;
            $display("Fail t=%0t %s expected %b actual %b", $time, sig, exp, act);
        end
    endtask

    task automatic check_word(input string sig, input logic [PROD_W-1:0] exp,
                              input logic [PROD_W-1:0] act);
        if (act !== exp) begin
            test_err++;
            $display("Fail t=%0t %s expected %h actual %h", $time, sig, exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_err == 0) begin
            $display("pass  %s", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_err);
        end
    endtask

    // one start pulse, then watch busy/done/product every cycle until done
    task automatic run_product(input string name, input logic [DATA_W-1:0] a,
                               input logic [DATA_W-1:0] b, input bit noise);
        logic [PROD_W-1:0] prev;
        int n;
        bit seen;
        test_err = 0;
        @(negedge clk);
        prev             = product;
        multiplicand     = a;
        multiplier       = b;
        start            = 1'b1;
        expected_product = signed_product(a, b);
        n    = 0; // rising edges since the start edge
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);
            start = 1'b0;
            if (done) begin
                seen = 1'b1;
                if (n != STEPS) begin
                    test_err++;
                    $display("done came %0d cycles after start instead of %0d", n, STEPS);
                end
                check_bit("busy", 1'b0, busy);
                check_word("product", expected_product, product);
            end else begin
                if (n < STEPS) begin
                    check_bit("busy", 1'b1, busy);
                end
                check_word("product", prev, product); // old result held
            end
            if (noise && !seen && n <= STEPS - 2 && n % 2 == 1) begin
                start        = 1'b1; // must be ignored while busy
                multiplicand = ~a;
                multiplier   = b ^ 8'h5a;
            end
            n++;
        end
        if (!seen) begin
            test_err++;
            $display("done never rose for %s", name);
        end
        @(negedge clk);
        check_bit("done", 1'b0, done);
        finish_test(name);
    endtask

    task automatic mid_reset_test();
        test_err = 0;
        @(negedge clk);
        multiplicand     = 8'h5b;
        multiplier       = 8'ha7;
        start            = 1'b1;
        expected_product = signed_product(8'h5b, 8'ha7);
        @(negedge clk);
        start = 1'b0;
        repeat (3) @(negedge clk);
        check_bit("busy", 1'b1, busy);
        rst = 1'b0; // abort mid product
        @(negedge clk);
        check_bit("done", 1'b0, done);
        check_bit("busy", 1'b0, busy);
        check_word("product", '0, product);
        if (dut.u_ctrl.state !== ST_IDLE) begin
            test_err++;
            $display("controller state is not idle while reset is held");
        end
        repeat (RESET_CYCLES - 1) @(negedge clk);
        rst = 1'b1;
        finish_test("reset during multiplication");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        start        = 1'b0;
        multiplicand = '0;
        multiplier   = '0;
        expected_product = '0;
        cycle_count  = 0;
        test_err     = 0;
        tests_run    = 0;
        tests_failed = 0;
        assert_err   = 0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // corner operands
        run_product("zero times x", 8'h00, 8'h5a, 1'b0);
        run_product("one times minus one", 8'h01, 8'hff, 1'b0);
        run_product("min times min", 8'h80, 8'h80, 1'b0);
        run_product("min times max", 8'h80, 8'h7f, 1'b0);
        run_product("max times max", 8'h7f, 8'h7f, 1'b0);
        run_product("minus one squared", 8'hff, 8'hff, 1'b0);

        for (int i = 0; i < 20; i++) begin
            logic [DATA_W-1:0] ra;
            logic [DATA_W-1:0] rb;
            ra = DATA_W'($urandom);
            rb = DATA_W'($urandom);
            run_product($sformatf("random %0d", i), ra, rb, 1'b0);
        end

        run_product("start ignored while busy", 8'h35, 8'hc9, 1'b1);
        run_product("start ignored, negative", 8'hb3, 8'h2e, 1'b1);

        mid_reset_test();
        run_product("product after reset", 8'hd7, 8'h19, 1'b0);

        repeat (2) @(negedge clk);
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, assert_err);
        if (tests_failed == 0 && assert_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
design/booth_cfg_pkg.sv
design/booth_ctrl_pkg.sv
design/booth_controller.sv
design/booth_step_counter.sv
design/booth_datapath.sv
design/booth_multiplier.sv
verif/booth_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    -f sim.f \
    --top-module booth_tb \
    -o booth_sim

./obj_dir/booth_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
